// ==== bench/exu_assert.sv ====
module exu_assert (
    input logic clk,
    input logic arst_n,
    input logic valid,
    input logic flush,
    input logic busy,
    input logic res_valid,
    input logic mul_start,
    input logic div_start,
    input logic mul_done,
    input logic div_done
);

    // outputs stay quiet while reset is held
    reset_quiet: assert property (@(posedge clk) !arst_n |-> !busy && !res_valid)
        else $error("busy or res_valid high during reset");

    single_cycle_result: assert property (@(posedge clk) disable iff (!arst_n)
        valid && !busy && !mul_start && !div_start |=> res_valid)
        else $error("single-cycle issue without res_valid on the next cycle");

    // a cancelled operation drops busy one edge after the flush
    busy_fall_cause: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> $past(mul_done || div_done || flush))
        else $error("busy dropped without done or flush");

endmodule

bind exu_top exu_assert u_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid     (valid),
    .flush     (flush),
    .busy      (busy),
    .res_valid (res_valid),
    .mul_start (mul_start),
    .div_start (div_start),
    .mul_done  (mul_done),
    .div_done  (div_done)
);

// ==== bench/exu_checker.sv ====
module exu_checker #(
    parameter int mul_step = 2
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             valid,
    input  exu_pkg::alu_op_t op,
    input  exu_pkg::sel_t    sel_a,
    input  exu_pkg::sel_t    sel_b,
    input  logic             rs1to32,
    input  exu_pkg::word_t   pc,
    input  exu_pkg::word_t   rs1,
    input  exu_pkg::word_t   rs2,
    input  exu_pkg::word_t   csr,
    input  exu_pkg::word_t   imm,
    input  logic             flush,
    input  exu_pkg::word_t   res,
    input  logic             res_valid,
    input  logic             busy,
    output int               errors,
    output int               pending
);
    import exu_pkg::*;

    word_t exp_q[$];
    int    lat_q[$];
    int    iss_q[$];
    int    cyc = 0;
    int    err_cnt = 0;
    logic  mc_live = 1'b0;
    int    mc_issue = 0;
    int    mc_lat = 0;
    logic  was_flushed = 1'b0;

    assign errors = err_cnt;

    task automatic check_value(input string name, input word_t expv, input word_t got);
        if (got !== expv) begin
            err_cnt++;
            $display("[FAIL] %s: expected %h, got %h at cycle %0d", name, expv, got, cyc);
        end
    endtask

    function automatic word_t ref_result(alu_op_t o, word_t x, word_t y, logic to32);
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        logic signed [63:0] sa;
        logic signed [63:0] sq;
        logic signed [63:0] sr;
        logic signed [31:0] lo;
        logic [5:0]         sh;
        logic               ovf;
        word_t              r;
        sx  = x;
        sy  = y;
        lo  = x[31:0];
        sh  = y[5:0];
        ovf = (x == {1'b1, 63'b0}) && (y == '1);
        sa  = sx >>> sh;
        sq  = '0;
        sr  = '0;
        // signed quotient and remainder only where both are defined
        if (y != '0 && !ovf) begin
            sq = sx / sy;
            sr = sx % sy;
        end
        case (o)
            op_add:   r = x + y;
            op_sub:   r = x - y;
            op_ret_a: r = x;
            op_ret_b: r = y;
            op_xor:   r = x ^ y;
            op_or:    r = x | y;
            op_and:   r = x & y;
            op_sll:   r = x << sh;
            op_srl:   r = x >> sh;
            op_sra:   r = to32 ? {32'b0, lo >>> sh} : sa;
            op_slt:   r = {63'b0, sx < sy};
            op_sltu:  r = {63'b0, x < y};
            op_eq:    r = {63'b0, x == y};
            op_ge:    r = {63'b0, sx >= sy};
            op_geu:   r = {63'b0, x >= y};
            op_mul:   r = x * y;
            op_div:   r = (y == '0) ? '1 : (ovf ? x : sq);
            op_rem:   r = (y == '0) ? x : (ovf ? '0 : sr);
            op_divu:  r = (y == '0) ? '1 : x / y;
            op_remu:  r = (y == '0) ? x : x % y;
            default:  r = '0;
        endcase
        return r;
    endfunction

    // edges from the issue edge until the result is registered
    function automatic int reg_latency(alu_op_t o);
        if (o == op_mul) begin
            return 64 / mul_step + 1;
        end else if (o == op_div || o == op_divu || o == op_rem || o == op_remu) begin
            return 65;
        end
        return 0;
    endfunction

    always @(posedge clk) begin
        word_t a_v;
        word_t b_v;
        word_t exp_v;
        int    lat_v;
        int    iss_v;
        cyc++;
        if (!arst_n) begin
            // first edge may still see values from before reset took hold
            if (cyc > 1) begin
                check_value("res", '0, res);
                check_value("res_valid", '0, 64'(res_valid));
                check_value("busy", '0, 64'(busy));
            end
        end else begin
            if (was_flushed) begin
                check_value("busy", '0, 64'(busy));
                was_flushed = 1'b0;
            end
            if (res_valid) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("result at cycle %0d with no operation outstanding", cyc);
                end else begin
                    exp_v = exp_q.pop_front();
                    lat_v = lat_q.pop_front();
                    iss_v = iss_q.pop_front();
                    check_value("res", exp_v, res);
                    check_value("res_valid latency", 64'(lat_v + 1), 64'(cyc - iss_v));
                    if (lat_v > 0) begin
                        check_value("busy", '0, 64'(busy));
                        mc_live = 1'b0;
                    end
                end
            end
            // multi-cycle op in flight
            if (mc_live && cyc > mc_issue && cyc <= mc_issue + mc_lat) begin
                check_value("busy", 64'd1, 64'(busy));
                if (flush) begin
                    void'(exp_q.pop_back());
                    void'(lat_q.pop_back());
                    void'(iss_q.pop_back());
                    mc_live     = 1'b0;
                    was_flushed = 1'b1;
                end
            end
            if (valid && busy) begin
                err_cnt++;
                $display("valid raised while busy at cycle %0d", cyc);
            end
            if (valid && !busy) begin
                a_v = pc;
                if (sel_a == 2'd1) begin
                    a_v = rs1to32 ? {32'b0, rs1[31:0]} : rs1;
                end
                b_v = imm;
                if (sel_b == 2'd1) begin
                    b_v = rs2;
                end else if (sel_b == 2'd2) begin
                    b_v = csr;
                end
                lat_v = reg_latency(op);
                exp_q.push_back(ref_result(op, a_v, b_v, rs1to32));
                lat_q.push_back(lat_v);
                iss_q.push_back(cyc);
                if (lat_v > 0) begin
                    mc_live  = 1'b1;
                    mc_issue = cyc;
                    mc_lat   = lat_v;
                end
            end
        end
        pending = exp_q.size();
    end

endmodule

// ==== bench/tb_exu.sv ====
module tb_exu;
    import exu_pkg::*;

    localparam int mul_step   = 2;
    localparam int n_ops      = 600;
    // worst op is a div after the longest idle gap
    localparam int max_cycles = n_ops * 70 + 5000;

    logic        clk;
    logic        arst_n;
    logic        valid;
    alu_op_t     op;
    sel_t        sel_a;
    sel_t        sel_b;
    logic        rs1to32;
    word_t       pc;
    word_t       rs1;
    word_t       rs2;
    word_t       csr;
    word_t       imm;
    logic        flush;
    word_t       res;
    logic        res_valid;
    logic        busy;
    int          chk_errors;
    int          pending;
    int          issued = 0;
    int          cycles = 0;
    logic [31:0] lfsr;

    exu_top #(
        .mul_step (mul_step)
    ) uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid     (valid),
        .op        (op),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .rs1to32   (rs1to32),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .flush     (flush),
        .res       (res),
        .res_valid (res_valid),
        .busy      (busy)
    );

    exu_checker #(
        .mul_step (mul_step)
    ) u_chk (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid     (valid),
        .op        (op),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .rs1to32   (rs1to32),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .flush     (flush),
        .res       (res),
        .res_valid (res_valid),
        .busy      (busy),
        .errors    (chk_errors),
        .pending   (pending)
    );

    always #10 clk = ~clk;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic draw(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic draw_operand(output word_t v);
        word_t kind;
        draw(3, kind);
        case (kind[2:0])
            3'd0: v = '0;
            3'd1: v = '1;
            3'd2: v = {1'b1, 63'b0};
            3'd3: draw(6, v);
            3'd4: v = 64'd1;
            default: draw(64, v);
        endcase
    endtask

    task automatic draw_issue();
        word_t r;
        draw(3, r);
        case (r[2:0])
            3'd4: op = op_mul;
            3'd5, 3'd6: begin
                draw(2, r);
                op = op_div + {3'b0, r[1:0]};
            end
            // codes above remu are unused
            3'd7: begin
                draw(3, r);
                op = 5'd20 + {2'b0, r[2:0]};
            end
            default: begin
                draw(4, r);
                op = (r[3:0] == 4'd15) ? op_sra : {1'b0, r[3:0]};
            end
        endcase
        draw(2, r);
        sel_a = r[1:0];
        draw(2, r);
        sel_b = r[1:0];
        draw(2, r);
        rs1to32 = (r[1:0] == 2'd0);
        draw_operand(pc);
        draw_operand(rs1);
        draw_operand(rs2);
        draw_operand(csr);
        draw_operand(imm);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("operations issued: %0d, errors: %0d", issued, chk_errors + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        word_t r;
        int    k;
        int    flush_at;
        clk     = 1'b0;
        arst_n  = 1'b0;
        valid   = 1'b0;
        flush   = 1'b0;
        op      = op_add;
        sel_a   = '0;
        sel_b   = '0;
        rs1to32 = 1'b0;
        pc      = '0;
        rs1     = '0;
        rs2     = '0;
        csr     = '0;
        imm     = '0;
        lfsr    = 32'h84e7;
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        for (int n = 0; n < n_ops; n++) begin
            draw(2, r);
            if (r[1:0] == 2'd0) begin
                draw(3, r);
                repeat (int'(r[2:0])) begin
                    @(posedge clk);
                    #2;
                end
            end
            draw_issue();
            // flush along with an issue, start wins
            draw(4, r);
            flush = (r[3:0] == 4'd0);
            valid = 1'b1;
            @(posedge clk);
            #2;
            valid = 1'b0;
            flush = 1'b0;
            issued++;
            flush_at = 0;
            draw(3, r);
            if (busy && r[2:0] == 3'd0) begin
                draw(6, r);
                flush_at = int'(r[5:0]) + 1;
            end
            k = 0;
            while (busy) begin
                k++;
                flush = (k == flush_at);
                @(posedge clk);
                #2;
            end
            flush = 1'b0;
        end
        while (pending != 0) begin
            @(posedge clk);
            #2;
        end
        // a few idle cycles to catch stray results
        repeat (3) @(posedge clk);
        #2;
        $display("operations issued: %0d, errors: %0d", issued, chk_errors);
        if (chk_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== rtl/exu_alu.sv ====
module exu_alu (
    input  exu_pkg::alu_op_t op,
    input  exu_pkg::sel_t    sel_a,
    input  exu_pkg::sel_t    sel_b,
    input  logic             rs1to32,
    input  exu_pkg::word_t   pc,
    input  exu_pkg::word_t   rs1,
    input  exu_pkg::word_t   rs2,
    input  exu_pkg::word_t   csr,
    input  exu_pkg::word_t   imm,
    output exu_pkg::word_t   a,
    output exu_pkg::word_t   b,
    output exu_pkg::word_t   alu_res
);
    import exu_pkg::*;

    logic [5:0]         shamt;
    logic signed [31:0] sra_lo;
    word_t              sra_res;

    // operand a: rs1 (optionally truncated) or pc
    assign a = (sel_a == 2'd1) ? (rs1to32 ? {32'b0, rs1[31:0]} : rs1) : pc;

    // operand b: rs2, csr, otherwise imm
    assign b = (sel_b == 2'd1) ? rs2 :
               (sel_b == 2'd2) ? csr : imm;

    assign shamt = b[5:0];

    // 32-bit arithmetic shift keeps upper half zero
    assign sra_lo = $signed(a[31:0]) >>> shamt;

    always_comb begin
        if (rs1to32) begin
            sra_res = {32'b0, sra_lo};
        end else begin
            sra_res = $signed(a) >>> shamt;
        end
    end

    always_comb begin
        case (op)
            op_add: begin
                alu_res = a + b;
            end
            op_sub: begin
                alu_res = a - b;
            end
            op_ret_a: begin
                alu_res = a;
            end
            op_ret_b: begin
                alu_res = b;
            end
            op_xor: begin
                alu_res = a ^ b;
            end
            op_or: begin
                alu_res = a | b;
            end
            op_and: begin
                alu_res = a & b;
            end
            op_sll: begin
                alu_res = a << shamt;
            end
            op_srl: begin
                alu_res = a >> shamt;
            end
            op_sra: begin
                alu_res = sra_res;
            end
            op_slt: begin
                alu_res = {63'b0, $signed(a) < $signed(b)};
            end
            op_sltu: begin
                alu_res = {63'b0, a < b};
            end
            op_eq: begin
                alu_res = {63'b0, a == b};
            end
            op_ge: begin
                alu_res = {63'b0, $signed(a) >= $signed(b)};
            end
            op_geu: begin
                alu_res = {63'b0, a >= b};
            end
            // mul, div family and unused codes
            default: begin
                alu_res = '0;
            end
        endcase
    end

endmodule

// ==== rtl/exu_ctrl.sv ====
module exu_ctrl (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             valid,
    input  exu_pkg::alu_op_t op,
    input  exu_pkg::word_t   alu_res,
    input  logic             mul_done,
    input  exu_pkg::word_t   mul_res,
    input  logic             div_done,
    input  exu_pkg::word_t   div_res,
    input  logic             mul_busy,
    input  logic             div_busy,
    output logic             mul_start,
    output logic             div_start,
    output exu_pkg::word_t   res,
    output logic             res_valid,
    output logic             busy
);
    import exu_pkg::*;

    logic accept;
    logic is_mul;
    logic is_div;
    logic busy_q;

    assign is_mul = (op == op_mul);
    assign is_div = (op == op_div) || (op == op_divu) ||
                    (op == op_rem) || (op == op_remu);

    assign accept    = valid && !busy;
    assign mul_start = accept && is_mul;
    assign div_start = accept && is_div;

    // drops as soon as a flushed unit is back to idle
    assign busy = busy_q && (mul_busy || div_busy);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
        end else if (mul_start || div_start) begin
            busy_q <= 1'b1;
        end else if (mul_done || div_done || !(mul_busy || div_busy)) begin
            busy_q <= 1'b0;
        end
    end

    // result register, one valid cycle per operation
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res       <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            if (accept && !is_mul && !is_div) begin
                res       <= alu_res;
                res_valid <= 1'b1;
            end else if (mul_done) begin
                res       <= mul_res;
                res_valid <= 1'b1;
            end else if (div_done) begin
                res       <= div_res;
                res_valid <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/exu_div.sv ====
module exu_div (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             start,
    input  logic             flush,
    input  exu_pkg::alu_op_t op,
    input  exu_pkg::word_t   a,
    input  exu_pkg::word_t   b,
    output logic             done,
    output exu_pkg::word_t   div_res,
    output logic             busy
);
    import exu_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_run,
        s_done
    } div_state_t;

    div_state_t  state;
    logic [5:0]  cnt;
    logic        is_signed;
    logic        want_rem;
    logic        neg_q;
    logic        neg_r;
    logic        div_zero;
    word_t       divisor;
    word_t       quo;
    word_t       rem;
    logic [64:0] shifted;
    logic        fits;
    word_t       q_fix;
    word_t       r_fix;

    assign is_signed = (op == op_div) || (op == op_rem);

    // one restoring step
    assign shifted = {rem, quo[63]};
    assign fits    = (shifted >= {1'b0, divisor});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
            cnt   <= '0;
        end else if (start) begin
            state <= s_run;
            cnt   <= '0;
        end else if (flush) begin
            state <= s_idle;
        end else begin
            case (state)
                s_run: begin
                    cnt <= cnt + 6'd1;
                    if (cnt == 6'd63) begin
                        state <= s_done;
                    end
                end
                s_done: begin
                    state <= s_idle;
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // quo holds the dividend magnitude and shifts quotient bits in from the right
    always_ff @(posedge clk) begin
        if (start) begin
            want_rem <= (op == op_rem) || (op == op_remu);
            neg_q    <= is_signed && (a[63] ^ b[63]);
            neg_r    <= is_signed && a[63];
            div_zero <= (b == '0);
            quo      <= (is_signed && a[63]) ? -a : a;
            divisor  <= (is_signed && b[63]) ? -b : b;
            rem      <= '0;
        end else if (state == s_run) begin
            if (fits) begin
                rem <= 64'(shifted - {1'b0, divisor});
                quo <= {quo[62:0], 1'b1};
            end else begin
                rem <= shifted[63:0];
                quo <= {quo[62:0], 1'b0};
            end
        end
    end

    // sign fix in the done cycle
    // overflow falls out naturally, |min| / 1 negates back to min
    always_comb begin
        if (div_zero) begin
            q_fix = '1;
        end else begin
            q_fix = neg_q ? -quo : quo;
        end
        r_fix = neg_r ? -rem : rem;
    end

    assign div_res = want_rem ? r_fix : q_fix;
    assign done    = (state == s_done) && !flush;
    assign busy    = (state != s_idle);

endmodule

// ==== rtl/exu_mul.sv ====
module exu_mul #(
    parameter int mul_step = 2
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           start,
    input  logic           flush,
    input  exu_pkg::word_t a,
    input  exu_pkg::word_t b,
    output logic           done,
    output exu_pkg::word_t mul_res,
    output logic           busy
);
    import exu_pkg::*;

    localparam int n_steps = 64 / mul_step;

    typedef enum logic [1:0] {
        s_idle,
        s_run,
        s_done
    } mul_state_t;

    mul_state_t state;
    logic [5:0] cnt;
    word_t      mcand;
    word_t      mplier;
    word_t      acc;
    word_t      partial;

    // sum of the shifted multiplicand for the low mul_step multiplier bits
    always_comb begin
        partial = '0;
        for (int i = 0; i < mul_step; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
            cnt   <= '0;
        end else if (start) begin
            state <= s_run;
            cnt   <= '0;
        end else if (flush) begin
            state <= s_idle;
        end else begin
            case (state)
                s_run: begin
                    cnt <= cnt + 6'd1;
                    if (cnt == 6'(n_steps - 1)) begin
                        state <= s_done;
                    end
                end
                s_done: begin
                    state <= s_idle;
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (state == s_run) begin
            acc    <= acc + partial;
            mcand  <= mcand << mul_step;
            mplier <= mplier >> mul_step;
        end
    end

    assign done    = (state == s_done) && !flush;
    assign mul_res = acc;
    assign busy    = (state != s_idle);

endmodule

// ==== rtl/exu_pkg.sv ====
package exu_pkg;

    typedef logic [63:0] word_t;
    typedef logic [4:0]  alu_op_t;
    typedef logic [1:0]  sel_t;

    // single-cycle operations
    localparam alu_op_t op_add    = 5'd0;
    localparam alu_op_t op_sub    = 5'd1;
    localparam alu_op_t op_ret_a  = 5'd2;
    localparam alu_op_t op_ret_b  = 5'd3;
    localparam alu_op_t op_xor    = 5'd4;
    localparam alu_op_t op_or     = 5'd5;
    localparam alu_op_t op_and    = 5'd6;
    localparam alu_op_t op_sll    = 5'd7;
    localparam alu_op_t op_srl    = 5'd8;
    localparam alu_op_t op_sra    = 5'd9;
    localparam alu_op_t op_slt    = 5'd10;
    localparam alu_op_t op_sltu   = 5'd11;
    localparam alu_op_t op_eq     = 5'd12;
    localparam alu_op_t op_ge     = 5'd13;
    localparam alu_op_t op_geu    = 5'd14;

    // multi-cycle operations
    localparam alu_op_t op_mul    = 5'd15;
    localparam alu_op_t op_div    = 5'd16;
    localparam alu_op_t op_divu   = 5'd17;
    localparam alu_op_t op_rem    = 5'd18;
    localparam alu_op_t op_remu   = 5'd19;

endpackage

// ==== rtl/exu_top.sv ====
module exu_top #(
    parameter int mul_step = 2
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             valid,
    input  exu_pkg::alu_op_t op,
    input  exu_pkg::sel_t    sel_a,
    input  exu_pkg::sel_t    sel_b,
    input  logic             rs1to32,
    input  exu_pkg::word_t   pc,
    input  exu_pkg::word_t   rs1,
    input  exu_pkg::word_t   rs2,
    input  exu_pkg::word_t   csr,
    input  exu_pkg::word_t   imm,
    input  logic             flush,
    output exu_pkg::word_t   res,
    output logic             res_valid,
    output logic             busy
);
    import exu_pkg::*;

    word_t a;
    word_t b;
    word_t alu_res;
    word_t mul_res;
    word_t div_res;
    logic  mul_start;
    logic  mul_done;
    logic  mul_busy;
    logic  div_start;
    logic  div_done;
    logic  div_busy;

    exu_alu u_alu (
        .op      (op),
        .sel_a   (sel_a),
        .sel_b   (sel_b),
        .rs1to32 (rs1to32),
        .pc      (pc),
        .rs1     (rs1),
        .rs2     (rs2),
        .csr     (csr),
        .imm     (imm),
        .a       (a),
        .b       (b),
        .alu_res (alu_res)
    );

    exu_mul #(
        .mul_step (mul_step)
    ) u_mul (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (mul_start),
        .flush   (flush),
        .a       (a),
        .b       (b),
        .done    (mul_done),
        .mul_res (mul_res),
        .busy    (mul_busy)
    );

    exu_div u_div (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (div_start),
        .flush   (flush),
        .op      (op),
        .a       (a),
        .b       (b),
        .done    (div_done),
        .div_res (div_res),
        .busy    (div_busy)
    );

    exu_ctrl u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid     (valid),
        .op        (op),
        .alu_res   (alu_res),
        .mul_done  (mul_done),
        .mul_res   (mul_res),
        .div_done  (div_done),
        .div_res   (div_res),
        .mul_busy  (mul_busy),
        .div_busy  (div_busy),
        .mul_start (mul_start),
        .div_start (div_start),
        .res       (res),
        .res_valid (res_valid),
        .busy      (busy)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_exu -f tb.f -o tb_exu_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_exu_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0

// ==== tb.f ====
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/exu_mul.sv
rtl/exu_div.sv
rtl/exu_ctrl.sv
rtl/exu_top.sv
bench/exu_assert.sv
bench/exu_checker.sv
bench/tb_exu.sv
